/* verilog/fpFormatPkg.sv */
// floating-point format package with widths, register word views and unpacked operand
`default_nettype none

package fpFormatPkg;

  // ------------------------------
  // format widths
  // ------------------------------
  // register width is FLEN
  localparam int flen = 64;
  localparam int dNe  = 11;
  localparam int dNf  = 52;
  localparam int sLen = 32;
  localparam int sNe  = 8;
  localparam int sNf  = 23;

  // register file geometry
  localparam int regAddrW = 5;
  localparam int numRegs  = 2 ** regAddrW;

  // boxed canonical quiet NaNs
  localparam logic [flen-1:0] canonSingle = 64'hFFFFFFFF_7FC00000;
  localparam logic [flen-1:0] canonDouble = 64'h7FF80000_00000000;

  // ------------------------------
  // register word views
  // ------------------------------
  typedef struct packed {
    logic            sgn;
    logic [dNe-1:0]  exp;
    logic [dNf-1:0]  frac;
  } fpDouble_t;

  // single sits in the low half with ones above it
  typedef struct packed {
    logic [sLen-1:0] box;
    logic            sgn;
    logic [sNe-1:0]  exp;
    logic [sNf-1:0]  frac;
  } fpSingle_t;

  typedef union packed {
    fpDouble_t d;
    fpSingle_t s;
  } fpWord_u;

  // operand after unpacking, always in double bias
  typedef struct packed {
    logic            sgn;
    // subnormal and zero carry effective exponent 1
    logic [dNe-1:0]  exp;
    // hidden bit on top
    logic [dNf:0]    man;
    logic            nan;
    logic            snan;
    logic            zero;
    logic            inf;
    logic            subnorm;
    logic            badBox;
  } fpUnpacked_t;

endpackage

`default_nettype wire

/* verilog/fpOpPkg.sv */
// operation package with op codes, request and response bundles and class mask layout
`default_nettype none

package fpOpPkg;

  // ------------------------------
  // operation codes
  // ------------------------------
  typedef enum logic [3:0] {
    LOAD  = 4'd0,
    READ  = 4'd1,
    CLASS = 4'd2,
    SGNJ  = 4'd3,
    SGNJN = 4'd4,
    SGNJX = 4'd5,
    MIN   = 4'd6,
    MAX   = 4'd7,
    EQ    = 4'd8,
    LT    = 4'd9,
    LE    = 4'd10
  } fpOp_e;

  // one request per cycle, valid is a strobe
  typedef struct packed {
    logic                                 valid;
    fpOp_e                                op;
    // 1 for double, 0 for single
    logic                                 isDouble;
    logic [fpFormatPkg::regAddrW-1:0]     rs1;
    logic [fpFormatPkg::regAddrW-1:0]     rs2;
    logic [fpFormatPkg::regAddrW-1:0]     rd;
    logic [fpFormatPkg::flen-1:0]         intData;
  } fpReq_t;

  typedef struct packed {
    logic                                 valid;
    logic [fpFormatPkg::flen-1:0]         data;
    logic                                 invalid;
  } fpRsp_t;

  // ------------------------------
  // classification mask
  // ------------------------------
  typedef logic [9:0] classMask_t;

  localparam int clsNegInf  = 0;
  localparam int clsNegNorm = 1;
  localparam int clsNegSub  = 2;
  localparam int clsNegZero = 3;
  localparam int clsPosZero = 4;
  localparam int clsPosSub  = 5;
  localparam int clsPosNorm = 6;
  localparam int clsPosInf  = 7;
  localparam int clsSNan    = 8;
  localparam int clsQNan    = 9;

endpackage

`default_nettype wire

/* verilog/fpRegFile.sv */
// floating-point register file with two combinational reads and one synchronous write
`default_nettype none

module fpRegFile (
  input  logic                                  clk,
  input  logic                                  rstN,
  input  logic [fpFormatPkg::regAddrW-1:0]      rAddr1,
  input  logic [fpFormatPkg::regAddrW-1:0]      rAddr2,
  output fpFormatPkg::fpWord_u                  rData1,
  output fpFormatPkg::fpWord_u                  rData2,
  input  logic                                  wEn,
  input  logic [fpFormatPkg::regAddrW-1:0]      wAddr,
  input  logic [fpFormatPkg::flen-1:0]          wData
);

  // register array
  logic [fpFormatPkg::flen-1:0] regs [fpFormatPkg::numRegs];

  // ------------------------------
  // write port
  // ------------------------------
  // all registers clear to zero on reset
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < fpFormatPkg::numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wEn) begin
      regs[wAddr] <= wData;
    end
  end

  // ------------------------------
  // read ports
  // ------------------------------
  // no bypass, a write lands before the next request reads
  assign rData1 = regs[rAddr1];
  assign rData2 = regs[rAddr2];

endmodule

`default_nettype wire

/* verilog/fpUnpack.sv */
// operand unpacker giving sign, double-bias exponent, significand and class flags
`default_nettype none

module fpUnpack (
  input  fpFormatPkg::fpWord_u                  word,
  input  logic                                  isDouble,
  input  logic                                  active,
  output fpFormatPkg::fpUnpacked_t              unpacked,
  output logic [fpFormatPkg::flen-1:0]          postBox
);

  localparam int dNe = fpFormatPkg::dNe;
  localparam int dNf = fpFormatPkg::dNf;
  localparam int sNe = fpFormatPkg::sNe;
  localparam int sNf = fpFormatPkg::sNf;

  fpFormatPkg::fpWord_u gated;
  logic                 badBox;
  logic                 sgnRaw;
  logic [dNe-1:0]       expRaw;
  logic                 expNonZero;
  logic                 expMax;
  logic                 fracZero;
  logic [dNf-1:0]       frac;

  // idle operands read as zero
  assign gated = word & {fpFormatPkg::flen{active}};

  // ------------------------------
  // box check
  // ------------------------------
  // single needs all ones above bit 31
  assign badBox  = active & ~isDouble & ~&gated.s.box;
  // bad box becomes the canonical single NaN
  assign postBox = badBox ? fpFormatPkg::canonSingle : gated;

  // ------------------------------
  // field extraction
  // ------------------------------
  always_comb begin
    if (isDouble) begin
      sgnRaw     = gated.d.sgn;
      expRaw     = gated.d.exp;
      expNonZero = |gated.d.exp;
      expMax     = &gated.d.exp;
      frac       = gated.d.frac;
    end else begin
      sgnRaw     = gated.s.sgn;
      // rebias 127 to 1023: keep top bit, fill the new bits with its inverse
      expRaw     = {gated.s.exp[sNe-1], {(dNe-sNe){~gated.s.exp[sNe-1]}},
                    gated.s.exp[sNe-2:0]};
      expNonZero = |gated.s.exp;
      expMax     = &gated.s.exp;
      // left align so the quiet bit lands at the same place
      frac       = {gated.s.frac, {(dNf-sNf){1'b0}}};
    end
  end

  // bad box never counts as a zero fraction
  assign fracZero = ~|frac & ~badBox;

  // ------------------------------
  // unpacked operand
  // ------------------------------
  always_comb begin
    // improperly boxed value is a positive NaN
    unpacked.sgn     = sgnRaw & ~badBox;
    // zero and subnormal take effective exponent 1
    unpacked.exp     = {expRaw[dNe-1:1], expRaw[0] | ~expNonZero};
    // hidden bit is set only for normals
    unpacked.man     = {expNonZero, frac};
    unpacked.nan     = (expMax & ~fracZero) | badBox;
    // quiet bit clear marks signaling
    unpacked.snan    = expMax & ~fracZero & ~frac[dNf-1] & ~badBox;
    unpacked.inf     = expMax & fracZero;
    unpacked.zero    = ~expNonZero & fracZero;
    unpacked.subnorm = ~expNonZero & ~fracZero & ~badBox;
    unpacked.badBox  = badBox;
  end

endmodule

`default_nettype wire

/* verilog/fpClassify.sv */
// classification unit building the one-hot 10-bit class mask
`default_nettype none

module fpClassify (
  input  fpFormatPkg::fpUnpacked_t              unpacked,
  input  logic                                  isDouble,
  output fpOpPkg::classMask_t                   mask
);

  logic normal;
  logic boxNan;

  // normal is whatever is left over
  assign normal = ~unpacked.nan & ~unpacked.inf & ~unpacked.zero & ~unpacked.subnorm;

  // only a single can be badly boxed, it reads as quiet
  assign boxNan = unpacked.badBox & ~isDouble;

  // exactly one bit set
  always_comb begin
    mask = '0;
    if (unpacked.nan) begin
      if (unpacked.snan & ~boxNan) begin
        mask[fpOpPkg::clsSNan] = 1'b1;
      end else begin
        mask[fpOpPkg::clsQNan] = 1'b1;
      end
    end else if (unpacked.inf) begin
      mask[unpacked.sgn ? fpOpPkg::clsNegInf : fpOpPkg::clsPosInf] = 1'b1;
    end else if (unpacked.zero) begin
      mask[unpacked.sgn ? fpOpPkg::clsNegZero : fpOpPkg::clsPosZero] = 1'b1;
    end else if (unpacked.subnorm) begin
      mask[unpacked.sgn ? fpOpPkg::clsNegSub : fpOpPkg::clsPosSub] = 1'b1;
    end else if (normal) begin
      mask[unpacked.sgn ? fpOpPkg::clsNegNorm : fpOpPkg::clsPosNorm] = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/fpSignInject.sv */
// sign injection for SGNJ, SGNJN and SGNJX in both formats
`default_nettype none

module fpSignInject (
  input  fpFormatPkg::fpUnpacked_t              opX,
  input  fpFormatPkg::fpUnpacked_t              opY,
  input  logic [fpFormatPkg::flen-1:0]          wordX,
  input  fpOpPkg::fpOp_e                        op,
  input  logic                                  isDouble,
  output logic [fpFormatPkg::flen-1:0]          result
);

  logic                 sgnNew;
  fpFormatPkg::fpWord_u res;

  // new sign from Y
  always_comb begin
    case (op)
      fpOpPkg::SGNJN: sgnNew = ~opY.sgn;
      fpOpPkg::SGNJX: sgnNew = opX.sgn ^ opY.sgn;
      default:        sgnNew = opY.sgn;
    endcase
  end

  // magnitude bits come from the reboxed X word
  always_comb begin
    res = wordX;
    if (isDouble) begin
      res.d.sgn = sgnNew;
    end else begin
      // result stays boxed
      res.s.box = '1;
      res.s.sgn = sgnNew;
    end
  end

  assign result = res;

endmodule

`default_nettype wire

/* verilog/fpCompare.sv */
// compare unit for EQ, LT and LE plus MIN/MAX selection and the invalid flag
`default_nettype none

module fpCompare (
  input  fpFormatPkg::fpUnpacked_t              opX,
  input  fpFormatPkg::fpUnpacked_t              opY,
  input  logic [fpFormatPkg::flen-1:0]          wordX,
  input  logic [fpFormatPkg::flen-1:0]          wordY,
  input  fpOpPkg::fpOp_e                        op,
  input  logic                                  isDouble,
  output logic                                  cmpResult,
  output logic [fpFormatPkg::flen-1:0]          minMax,
  output logic                                  invalid
);

  logic anyNan;
  logic anySnan;
  logic bothZero;
  logic magEq;
  logic magLt;
  logic eq;
  logic lt;
  logic pickX;

  assign anyNan   = opX.nan | opY.nan;
  assign anySnan  = opX.snan | opY.snan;
  assign bothZero = opX.zero & opY.zero;

  // ------------------------------
  // ordering
  // ------------------------------
  // exponent then significand gives magnitude order
  assign magEq = {opX.exp, opX.man} == {opY.exp, opY.man};
  assign magLt = {opX.exp, opX.man} <  {opY.exp, opY.man};

  // signed zeros are equal
  assign eq = bothZero | (magEq & (opX.sgn == opY.sgn));

  always_comb begin
    if (bothZero) begin
      lt = 1'b0;
    end else if (opX.sgn != opY.sgn) begin
      // negative X is below positive Y
      lt = opX.sgn;
    end else if (opX.sgn) begin
      // both negative so larger magnitude is smaller
      lt = ~magLt & ~magEq;
    end else begin
      lt = magLt;
    end
  end

  // ------------------------------
  // compare result and invalid
  // ------------------------------
  always_comb begin
    case (op)
      fpOpPkg::EQ: cmpResult = eq & ~anyNan;
      fpOpPkg::LT: cmpResult = lt & ~anyNan;
      fpOpPkg::LE: cmpResult = (lt | eq) & ~anyNan;
      default:     cmpResult = 1'b0;
    endcase
  end

  // ordered compares trap on quiet NaNs as well
  always_comb begin
    case (op)
      fpOpPkg::LT, fpOpPkg::LE:               invalid = anyNan;
      fpOpPkg::EQ, fpOpPkg::MIN, fpOpPkg::MAX: invalid = anySnan;
      default:                                 invalid = 1'b0;
    endcase
  end

  // ------------------------------
  // min / max selection
  // ------------------------------
  // MIN takes X when smaller, or on equal zeros when X is -0
  // MAX takes the other one so it prefers +0
  always_comb begin
    if (op == fpOpPkg::MAX) begin
      pickX = ~(lt | (eq & opX.sgn));
    end else begin
      pickX = lt | (eq & opX.sgn);
    end
  end

  always_comb begin
    if (opX.nan & opY.nan) begin
      minMax = isDouble ? fpFormatPkg::canonDouble : fpFormatPkg::canonSingle;
    end else if (opX.nan) begin
      minMax = wordY;
    end else if (opY.nan) begin
      minMax = wordX;
    end else begin
      minMax = pickX ? wordX : wordY;
    end
  end

endmodule

`default_nettype wire

/* verilog/fpWriteback.sv */
// writeback stage with op decode, register write and registered response
`default_nettype none

module fpWriteback (
  input  logic                                  clk,
  input  logic                                  rstN,
  input  fpOpPkg::fpReq_t                       req,
  input  fpOpPkg::classMask_t                   classMask,
  input  logic [fpFormatPkg::flen-1:0]          sgnjResult,
  input  logic                                  cmpResult,
  input  logic [fpFormatPkg::flen-1:0]          minMax,
  input  logic                                  cmpInvalid,
  input  logic [fpFormatPkg::flen-1:0]          rawX,
  output logic                                  wEn,
  output logic [fpFormatPkg::regAddrW-1:0]      wAddr,
  output logic [fpFormatPkg::flen-1:0]          wData,
  output fpOpPkg::fpRsp_t                       rsp
);

  localparam int flen = fpFormatPkg::flen;

  logic            isLoad;
  logic            isSgnj;
  logic            isMinMax;
  logic            isCmp;
  fpOpPkg::fpRsp_t rspNext;

  // ------------------------------
  // op decode
  // ------------------------------
  assign isLoad   = req.op == fpOpPkg::LOAD;
  assign isSgnj   = req.op inside {fpOpPkg::SGNJ, fpOpPkg::SGNJN, fpOpPkg::SGNJX};
  assign isMinMax = req.op inside {fpOpPkg::MIN, fpOpPkg::MAX};
  assign isCmp    = req.op inside {fpOpPkg::EQ, fpOpPkg::LT, fpOpPkg::LE};

  // ------------------------------
  // register write
  // ------------------------------
  assign wEn   = req.valid & (isLoad | isSgnj | isMinMax);
  assign wAddr = req.rd;

  always_comb begin
    if (isSgnj) begin
      wData = sgnjResult;
    end else if (isMinMax) begin
      wData = minMax;
    end else begin
      wData = req.intData;
    end
  end

  // ------------------------------
  // response
  // ------------------------------
  always_comb begin
    rspNext.valid = req.valid;
    case (req.op)
      fpOpPkg::CLASS: rspNext.data = {{(flen-$bits(classMask)){1'b0}}, classMask};
      fpOpPkg::READ:  rspNext.data = rawX;
      default:        rspNext.data = wData;
    endcase
    if (isCmp) begin
      rspNext.data = {{(flen-1){1'b0}}, cmpResult};
    end
    // flag only meaningful for compares and min/max
    rspNext.invalid = req.valid & (isCmp | isMinMax) & cmpInvalid;
  end

  // one cycle after the request
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rsp <= '0;
    end else begin
      rsp <= rspNext;
    end
  end

endmodule

`default_nettype wire

/* verilog/fpMiscUnit.sv */
// floating-point miscellaneous unit top with register file, unpackers and result units
`default_nettype none

module fpMiscUnit (
  input  logic                                  clk,
  input  logic                                  rstN,
  input  fpOpPkg::fpReq_t                       req,
  output fpOpPkg::fpRsp_t                       rsp
);

  fpFormatPkg::fpWord_u                 rData1;
  fpFormatPkg::fpWord_u                 rData2;
  fpFormatPkg::fpUnpacked_t             opX;
  fpFormatPkg::fpUnpacked_t             opY;
  logic [fpFormatPkg::flen-1:0]         postBoxX;
  logic [fpFormatPkg::flen-1:0]         postBoxY;
  logic [fpFormatPkg::flen-1:0]         sgnjResult;
  logic [fpFormatPkg::flen-1:0]         minMax;
  logic [fpFormatPkg::flen-1:0]         wData;
  logic [fpFormatPkg::regAddrW-1:0]     wAddr;
  logic                                 wEn;
  logic                                 cmpResult;
  logic                                 cmpInvalid;
  fpOpPkg::classMask_t                  classMask;

  // ------------------------------
  // operands
  // ------------------------------
  fpRegFile uRegFile (
    .clk(clk), .rstN(rstN),
    .rAddr1(req.rs1), .rAddr2(req.rs2),
    .rData1(rData1), .rData2(rData2),
    .wEn(wEn), .wAddr(wAddr), .wData(wData)
  );

  fpUnpack uUnpackX (
    .word(rData1), .isDouble(req.isDouble), .active(req.valid),
    .unpacked(opX), .postBox(postBoxX)
  );

  fpUnpack uUnpackY (
    .word(rData2), .isDouble(req.isDouble), .active(req.valid),
    .unpacked(opY), .postBox(postBoxY)
  );

  // ------------------------------
  // result units
  // ------------------------------
  fpClassify uClassify (
    .unpacked(opX), .isDouble(req.isDouble), .mask(classMask)
  );

  fpSignInject uSignInject (
    .opX(opX), .opY(opY), .wordX(postBoxX), .op(req.op),
    .isDouble(req.isDouble), .result(sgnjResult)
  );

  fpCompare uCompare (
    .opX(opX), .opY(opY), .wordX(postBoxX), .wordY(postBoxY), .op(req.op),
    .isDouble(req.isDouble), .cmpResult(cmpResult), .minMax(minMax),
    .invalid(cmpInvalid)
  );

  // raw X word feeds READ
  fpWriteback uWriteback (
    .clk(clk), .rstN(rstN), .req(req),
    .classMask(classMask), .sgnjResult(sgnjResult), .cmpResult(cmpResult),
    .minMax(minMax), .cmpInvalid(cmpInvalid), .rawX(rData1),
    .wEn(wEn), .wAddr(wAddr), .wData(wData), .rsp(rsp)
  );

endmodule

`default_nettype wire

/* tests/tbClockGen.sv */
// testbench clock source with a 100 ns period
`default_nettype none

module tbClockGen (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  // half of the 100 ns period
  localparam int halfPeriod = 50;

  // free running, low at time zero
  initial begin
    clk = 1'b0;
    forever begin
      #halfPeriod clk = ~clk;
    end
  end

endmodule

`default_nettype wire

/* tests/fpMiscTb.sv */
// table-driven testbench for the floating-point miscellaneous unit
`default_nettype none

module fpMiscTb;

  timeunit 1ns;
  timeprecision 1ps;

  // one request with the response it must produce
  typedef struct {
    string                        name;
    fpOpPkg::fpReq_t              req;
    logic [fpFormatPkg::flen-1:0] expData;
    logic                         expInvalid;
  } tableRow_t;

  logic            clk;
  logic            rstN;
  fpOpPkg::fpReq_t req;
  fpOpPkg::fpRsp_t rsp;
  tableRow_t       rows[$];
  logic [31:0]     rngState = 32'h7190_d1cc;
  int              cycleCount = 0;
  int              cycleLimit = 0;
  logic            tableReady = 1'b0;

  tbClockGen clockGen (
    .clk(clk)
  );

  fpMiscUnit DUT (
    .clk(clk), .rstN(rstN), .req(req), .rsp(rsp)
  );

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  // xorshift32 step
  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  // sign injection on well boxed words, sign sits at bit 63 or bit 31
  function automatic logic [63:0] injectSign(input fpOpPkg::fpOp_e op, input int dbl,
                                             input logic [63:0] x, input logic [63:0] y);
    int          sBit;
    logic        sNew;
    logic [63:0] res;
    sBit = (dbl != 0) ? 63 : 31;
    case (op)
      fpOpPkg::SGNJN: sNew = ~y[sBit];
      fpOpPkg::SGNJX: sNew = x[sBit] ^ y[sBit];
      default:        sNew = y[sBit];
    endcase
    res       = x;
    res[sBit] = sNew;
    // single result keeps its box
    if (dbl == 0) begin
      res[63:32] = '1;
    end
    return res;
  endfunction

  task automatic loadRow(input string name, input int rd,
                         input logic [fpFormatPkg::flen-1:0] word);
    tableRow_t row;
    row.name         = name;
    row.req          = '0;
    row.req.valid    = 1'b1;
    row.req.op       = fpOpPkg::LOAD;
    row.req.isDouble = 1'b1;
    row.req.rd       = rd[4:0];
    row.req.intData  = word;
    // load echoes the written word
    row.expData      = word;
    row.expInvalid   = 1'b0;
    rows.push_back(row);
  endtask

  task automatic opRow(input string name, input fpOpPkg::fpOp_e op, input int dbl,
                       input int rs1, input int rs2, input int rd,
                       input logic [fpFormatPkg::flen-1:0] expData, input int expInv);
    tableRow_t row;
    row.name         = name;
    row.req          = '0;
    row.req.valid    = 1'b1;
    row.req.op       = op;
    row.req.isDouble = (dbl != 0);
    row.req.rs1      = rs1[4:0];
    row.req.rs2      = rs2[4:0];
    row.req.rd       = rd[4:0];
    row.expData      = expData;
    row.expInvalid   = (expInv != 0);
    rows.push_back(row);
  endtask

  // ------------------------------
  // stimulus table
  // ------------------------------
  task automatic buildTable();
    logic [63:0] dWord;
    logic [63:0] yWord;
    logic [63:0] sWord;
    logic [63:0] tWord;
    logic [63:0] expWord;
    // registers are clear after reset
    opRow("read r5 after reset", fpOpPkg::READ, 1, 5, 0, 0, 64'h0, 0);
    opRow("read r31 after reset", fpOpPkg::READ, 1, 31, 0, 0, 64'h0, 0);
    // doubles in r1..r10, read right behind the load
    loadRow("load d +1.0", 3, 64'h3FF0_0000_0000_0000);
    opRow("read d +1.0 back to back", fpOpPkg::READ, 1, 3, 0, 0, 64'h3FF0_0000_0000_0000, 0);
    loadRow("load d +0", 1, 64'h0000_0000_0000_0000);
    loadRow("load d -0", 2, 64'h8000_0000_0000_0000);
    loadRow("load d -2.0", 4, 64'hC000_0000_0000_0000);
    loadRow("load d +inf", 5, 64'h7FF0_0000_0000_0000);
    loadRow("load d -inf", 6, 64'hFFF0_0000_0000_0000);
    loadRow("load d qnan", 7, 64'h7FF8_0000_0000_0000);
    loadRow("load d snan", 8, 64'h7FF4_0000_0000_0000);
    loadRow("load d +sub", 9, 64'h0000_0000_0000_0001);
    loadRow("load d -sub", 10, 64'h800F_0000_0000_0000);
    // boxed singles in r11..r21, r18 has a broken box
    loadRow("load s +1.0", 11, 64'hFFFF_FFFF_3F80_0000);
    loadRow("load s -0", 12, 64'hFFFF_FFFF_8000_0000);
    loadRow("load s +0", 13, 64'hFFFF_FFFF_0000_0000);
    loadRow("load s -inf", 14, 64'hFFFF_FFFF_FF80_0000);
    loadRow("load s snan", 15, 64'hFFFF_FFFF_7FA0_0000);
    loadRow("load s qnan", 16, 64'hFFFF_FFFF_7FC0_0001);
    loadRow("load s +sub", 17, 64'hFFFF_FFFF_0000_0010);
    loadRow("load s bad box", 18, 64'h0000_0000_3F80_0000);
    opRow("read s bad box raw", fpOpPkg::READ, 0, 18, 0, 0, 64'h0000_0000_3F80_0000, 0);
    loadRow("load s -3.0", 19, 64'hFFFF_FFFF_C040_0000);
    loadRow("load s +inf", 20, 64'hFFFF_FFFF_7F80_0000);
    loadRow("load s -sub", 21, 64'hFFFF_FFFF_8000_0001);

    // one-hot class masks
    opRow("class d +0", fpOpPkg::CLASS, 1, 1, 0, 0, 64'h010, 0);
    opRow("class d -0", fpOpPkg::CLASS, 1, 2, 0, 0, 64'h008, 0);
    opRow("class d +normal", fpOpPkg::CLASS, 1, 3, 0, 0, 64'h040, 0);
    opRow("class d -normal", fpOpPkg::CLASS, 1, 4, 0, 0, 64'h002, 0);
    opRow("class d +inf", fpOpPkg::CLASS, 1, 5, 0, 0, 64'h080, 0);
    opRow("class d -inf", fpOpPkg::CLASS, 1, 6, 0, 0, 64'h001, 0);
    opRow("class d qnan", fpOpPkg::CLASS, 1, 7, 0, 0, 64'h200, 0);
    opRow("class d snan", fpOpPkg::CLASS, 1, 8, 0, 0, 64'h100, 0);
    opRow("class d +sub", fpOpPkg::CLASS, 1, 9, 0, 0, 64'h020, 0);
    opRow("class d -sub", fpOpPkg::CLASS, 1, 10, 0, 0, 64'h004, 0);
    opRow("class s +normal", fpOpPkg::CLASS, 0, 11, 0, 0, 64'h040, 0);
    opRow("class s -0", fpOpPkg::CLASS, 0, 12, 0, 0, 64'h008, 0);
    opRow("class s +0", fpOpPkg::CLASS, 0, 13, 0, 0, 64'h010, 0);
    opRow("class s -inf", fpOpPkg::CLASS, 0, 14, 0, 0, 64'h001, 0);
    opRow("class s snan", fpOpPkg::CLASS, 0, 15, 0, 0, 64'h100, 0);
    opRow("class s qnan", fpOpPkg::CLASS, 0, 16, 0, 0, 64'h200, 0);
    opRow("class s +sub", fpOpPkg::CLASS, 0, 17, 0, 0, 64'h020, 0);
    opRow("class s bad box", fpOpPkg::CLASS, 0, 18, 0, 0, 64'h200, 0);
    opRow("class s -normal", fpOpPkg::CLASS, 0, 19, 0, 0, 64'h002, 0);
    opRow("class s +inf", fpOpPkg::CLASS, 0, 20, 0, 0, 64'h080, 0);
    opRow("class s -sub", fpOpPkg::CLASS, 0, 21, 0, 0, 64'h004, 0);
    opRow("class double as single", fpOpPkg::CLASS, 0, 3, 0, 0, 64'h200, 0);

    // sign injection, results land in r28
    opRow("sgnj d", fpOpPkg::SGNJ, 1, 3, 4, 28, 64'hBFF0_0000_0000_0000, 0);
    opRow("read sgnj result", fpOpPkg::READ, 1, 28, 0, 0, 64'hBFF0_0000_0000_0000, 0);
    opRow("sgnjn d", fpOpPkg::SGNJN, 1, 3, 4, 28, 64'h3FF0_0000_0000_0000, 0);
    opRow("sgnjx d", fpOpPkg::SGNJX, 1, 4, 6, 28, 64'h4000_0000_0000_0000, 0);
    opRow("sgnjn d qnan", fpOpPkg::SGNJN, 1, 7, 1, 28, 64'hFFF8_0000_0000_0000, 0);
    opRow("sgnj s", fpOpPkg::SGNJ, 0, 11, 12, 28, 64'hFFFF_FFFF_BF80_0000, 0);
    opRow("sgnjn s", fpOpPkg::SGNJN, 0, 19, 19, 28, 64'hFFFF_FFFF_4040_0000, 0);
    opRow("sgnjx s", fpOpPkg::SGNJX, 0, 12, 19, 28, 64'hFFFF_FFFF_0000_0000, 0);
    // broken box source acts as the canonical single NaN
    opRow("sgnj s bad box x", fpOpPkg::SGNJ, 0, 18, 12, 28, 64'hFFFF_FFFF_FFC0_0000, 0);
    opRow("sgnj s bad box y", fpOpPkg::SGNJ, 0, 11, 18, 28, 64'hFFFF_FFFF_3F80_0000, 0);
    opRow("sgnjn s bad box y", fpOpPkg::SGNJN, 0, 11, 18, 28, 64'hFFFF_FFFF_BF80_0000, 0);

    // ordered compares
    opRow("eq d same", fpOpPkg::EQ, 1, 3, 3, 0, 64'h1, 0);
    opRow("eq d +0 -0", fpOpPkg::EQ, 1, 1, 2, 0, 64'h1, 0);
    opRow("lt d -0 +0", fpOpPkg::LT, 1, 2, 1, 0, 64'h0, 0);
    opRow("le d -0 +0", fpOpPkg::LE, 1, 2, 1, 0, 64'h1, 0);
    opRow("lt d -2 +1", fpOpPkg::LT, 1, 4, 3, 0, 64'h1, 0);
    opRow("lt d +1 -2", fpOpPkg::LT, 1, 3, 4, 0, 64'h0, 0);
    opRow("le d -inf -2", fpOpPkg::LE, 1, 6, 4, 0, 64'h1, 0);
    opRow("lt d -2 -sub", fpOpPkg::LT, 1, 4, 10, 0, 64'h1, 0);
    opRow("lt d +sub +1", fpOpPkg::LT, 1, 9, 3, 0, 64'h1, 0);
    opRow("le d +inf +inf", fpOpPkg::LE, 1, 5, 5, 0, 64'h1, 0);
    // NaN operands give 0, quiet NaN only traps on LT and LE
    opRow("eq d qnan", fpOpPkg::EQ, 1, 7, 3, 0, 64'h0, 0);
    opRow("eq d snan", fpOpPkg::EQ, 1, 8, 3, 0, 64'h0, 1);
    opRow("lt d qnan", fpOpPkg::LT, 1, 7, 3, 0, 64'h0, 1);
    opRow("le d qnan y", fpOpPkg::LE, 1, 3, 7, 0, 64'h0, 1);
    opRow("eq s -0 +0", fpOpPkg::EQ, 0, 12, 13, 0, 64'h1, 0);
    opRow("lt s -3 +1", fpOpPkg::LT, 0, 19, 11, 0, 64'h1, 0);
    opRow("le s +1 -3", fpOpPkg::LE, 0, 11, 19, 0, 64'h0, 0);
    opRow("lt s +sub +1", fpOpPkg::LT, 0, 17, 11, 0, 64'h1, 0);
    opRow("lt s -inf -sub", fpOpPkg::LT, 0, 14, 21, 0, 64'h1, 0);
    opRow("eq s bad box", fpOpPkg::EQ, 0, 18, 18, 0, 64'h0, 0);
    opRow("lt s qnan", fpOpPkg::LT, 0, 16, 11, 0, 64'h0, 1);
    opRow("eq s snan", fpOpPkg::EQ, 0, 15, 11, 0, 64'h0, 1);

    // min and max, results land in r29
    opRow("min d +0 -0", fpOpPkg::MIN, 1, 1, 2, 29, 64'h8000_0000_0000_0000, 0);
    opRow("max d +0 -0", fpOpPkg::MAX, 1, 1, 2, 29, 64'h0000_0000_0000_0000, 0);
    opRow("min d -0 +0", fpOpPkg::MIN, 1, 2, 1, 29, 64'h8000_0000_0000_0000, 0);
    opRow("max d -0 +0", fpOpPkg::MAX, 1, 2, 1, 29, 64'h0000_0000_0000_0000, 0);
    opRow("min d +1 -2", fpOpPkg::MIN, 1, 3, 4, 29, 64'hC000_0000_0000_0000, 0);
    opRow("max d +1 -2", fpOpPkg::MAX, 1, 3, 4, 29, 64'h3FF0_0000_0000_0000, 0);
    opRow("min d qnan x", fpOpPkg::MIN, 1, 7, 3, 29, 64'h3FF0_0000_0000_0000, 0);
    opRow("max d snan y", fpOpPkg::MAX, 1, 4, 8, 29, 64'hC000_0000_0000_0000, 1);
    opRow("min d two nans", fpOpPkg::MIN, 1, 7, 8, 29, 64'h7FF8_0000_0000_0000, 1);
    opRow("max d two qnans", fpOpPkg::MAX, 1, 7, 7, 29, 64'h7FF8_0000_0000_0000, 0);
    opRow("min s -0 +0", fpOpPkg::MIN, 0, 12, 13, 29, 64'hFFFF_FFFF_8000_0000, 0);
    opRow("max s -0 +0", fpOpPkg::MAX, 0, 12, 13, 29, 64'hFFFF_FFFF_0000_0000, 0);
    opRow("max s -3 +1", fpOpPkg::MAX, 0, 19, 11, 29, 64'hFFFF_FFFF_3F80_0000, 0);
    opRow("min s bad box x", fpOpPkg::MIN, 0, 18, 19, 29, 64'hFFFF_FFFF_C040_0000, 0);
    opRow("min s snan qnan", fpOpPkg::MIN, 0, 15, 16, 29, 64'hFFFF_FFFF_7FC0_0000, 1);
    opRow("max s snan y", fpOpPkg::MAX, 0, 11, 15, 29, 64'hFFFF_FFFF_3F80_0000, 1);
    opRow("min s two bad boxes", fpOpPkg::MIN, 0, 18, 18, 29, 64'hFFFF_FFFF_7FC0_0000, 0);
    opRow("read min result", fpOpPkg::READ, 0, 29, 0, 0, 64'hFFFF_FFFF_7FC0_0000, 0);

    // random words, r24/r25 doubles and r26/r27 boxed singles
    for (int k = 0; k < 3; k++) begin
      dWord[63:32] = nextRandom();
      dWord[31:0]  = nextRandom();
      yWord[63:32] = nextRandom();
      yWord[31:0]  = nextRandom();
      sWord        = {32'hFFFF_FFFF, nextRandom()};
      tWord        = {32'hFFFF_FFFF, nextRandom()};
      loadRow($sformatf("rand %0d load d", k), 24, dWord);
      opRow($sformatf("rand %0d read d", k), fpOpPkg::READ, 1, 24, 0, 0, dWord, 0);
      loadRow($sformatf("rand %0d load d y", k), 25, yWord);
      loadRow($sformatf("rand %0d load s", k), 26, sWord);
      loadRow($sformatf("rand %0d load s y", k), 27, tWord);
      expWord = injectSign(fpOpPkg::SGNJX, 1, dWord, yWord);
      opRow($sformatf("rand %0d sgnjx d", k), fpOpPkg::SGNJX, 1, 24, 25, 30, expWord, 0);
      expWord = injectSign(fpOpPkg::SGNJ, 0, sWord, tWord);
      opRow($sformatf("rand %0d sgnj s", k), fpOpPkg::SGNJ, 0, 26, 27, 30, expWord, 0);
      expWord = injectSign(fpOpPkg::SGNJN, 0, sWord, sWord);
      opRow($sformatf("rand %0d sgnjn s", k), fpOpPkg::SGNJN, 0, 26, 26, 30, expWord, 0);
      opRow($sformatf("rand %0d read result", k), fpOpPkg::READ, 0, 30, 0, 0, expWord, 0);
    end
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic checkData(input string name, input logic [fpFormatPkg::flen-1:0] expected,
                           input fpOpPkg::fpRsp_t actual);
    if (actual.data !== expected) begin
      $display("[ERROR] %s data expected %h actual %h", name, expected, actual.data);
      $display("TEST FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic checkFlag(input string name, input logic expected,
                           input fpOpPkg::fpRsp_t actual);
    if (actual.invalid !== expected) begin
      $display("[ERROR] %s invalid expected %b actual %b", name, expected, actual.invalid);
      $display("TEST FAILED");
      $fatal(1, "invalid flag mismatch");
    end
  endtask

  task automatic requireValid(input string name, input fpOpPkg::fpRsp_t actual);
    if (actual.valid !== 1'b1) begin
      $display("no response arrived one cycle after request %s", name);
      $display("TEST FAILED");
      $fatal(1, "missing response");
    end
  endtask

  // ------------------------------
  // timeout
  // ------------------------------
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (tableReady && cycleCount > cycleLimit) begin
      $display("simulation did not finish within %0d cycles", cycleLimit);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    rstN      = 1'b0;
    // a live request during reset must not reach the response register
    req       = '0;
    req.valid = 1'b1;
    req.op    = fpOpPkg::READ;
    buildTable();
    cycleLimit = rows.size() * 2 + 20;
    tableReady = 1'b1;
    // reset over three rising edges, response looked at while it is held
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (rsp.valid !== 1'b0 || rsp.invalid !== 1'b0) begin
      $display("response flags were not clear during reset");
      $display("TEST FAILED");
      $fatal(1, "reset state");
    end
    @(posedge clk);
    rstN <= 1'b1;
    req  <= '0;
    // row i goes out while the response of row i-1 is checked
    for (int i = 0; i <= rows.size(); i++) begin
      @(posedge clk);
      if (i < rows.size()) begin
        req <= rows[i].req;
      end else begin
        req <= '0;
      end
      @(negedge clk);
      if (i > 0) begin
        requireValid(rows[i-1].name, rsp);
        checkData(rows[i-1].name, rows[i-1].expData, rsp);
        checkFlag(rows[i-1].name, rows[i-1].expInvalid, rsp);
      end
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* fpMisc.f */
verilog/fpFormatPkg.sv
verilog/fpOpPkg.sv
verilog/fpRegFile.sv
verilog/fpUnpack.sv
verilog/fpClassify.sv
verilog/fpSignInject.sv
verilog/fpCompare.sv
verilog/fpWriteback.sv
verilog/fpMiscUnit.sv
tests/tbClockGen.sv
tests/fpMiscTb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --top-module fpMiscTb -f fpMisc.f \
  -Mdir obj_dir -o fpMiscSim > build.log 2>&1 &&
  ./obj_dir/fpMiscSim > sim.log 2>&1 ||
  { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }

grep -q "^TEST PASSED$" sim.log &&
  { echo "simulation passed"; exit 0; } ||
  { echo "simulation failed"; cat sim.log; exit 1; }
